/* Makefile */
TOP = tb_spi_sub

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/spi_sub_pkg.sv */
`default_nettype none

package spi_sub_pkg;

    // Data path widths
    localparam int byte_w    = 8;
    localparam int bit_idx_w = $clog2(byte_w);     // Bit position within a byte
    localparam int count_w   = 32;                 // Data byte counter

    // Address map
    localparam logic [byte_w-1:0] addr_chip_id      = 8'h01;
    localparam logic [byte_w-1:0] chip_id_value     = 8'h5A;
    localparam logic [byte_w-1:0] addr_scratch_base = 8'h10;
    localparam int                scratch_count     = 4;    // 0x10 to 0x13
    localparam int                scratch_idx_w     = $clog2(scratch_count);
    localparam logic [byte_w-1:0] addr_fifo_data    = 8'h20; // Push on write, pop on read
    localparam logic [byte_w-1:0] addr_fifo_level   = 8'h21; // Stored byte count

    // FIFO sizing
    localparam int fifo_depth   = 8;
    localparam int fifo_ptr_w   = $clog2(fifo_depth);
    localparam int fifo_level_w = fifo_ptr_w + 1;  // Holds 0 up to depth

    // Transaction phase
    // Address byte first, then data bytes until deselect
    typedef enum logic {
        phase_address,
        phase_data
    } spi_phase_t;

endpackage

`default_nettype wire

/* files.f */
common/spi_sub_pkg.sv
spi_peripheral/spi_bit_counter.sv
spi_peripheral/spi_phase_control.sv
spi_peripheral/spi_shifter.sv
spi_peripheral/spi_peripheral.sv
rtl/register_bank.sv
rtl/byte_fifo.sv
rtl/spi_sub_top.sv
testbench/tb_spi_sub.sv

/* rtl/byte_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_fifo (
    input  logic                              spi_clock_in,
    input  logic                              spi_resetn,
    input  logic [spi_sub_pkg::byte_w-1:0]    address,
    input  logic                              wr_en,
    input  logic [spi_sub_pkg::byte_w-1:0]    wr_data,
    input  logic                              rd_en,
    output logic [spi_sub_pkg::byte_w-1:0]    response
);

    logic [spi_sub_pkg::byte_w-1:0]       mem [spi_sub_pkg::fifo_depth];
    logic [spi_sub_pkg::fifo_ptr_w-1:0]   wr_ptr;
    logic [spi_sub_pkg::fifo_ptr_w-1:0]   rd_ptr;
    logic [spi_sub_pkg::fifo_ptr_w-1:0]   next_rd_ptr;    // Head after this pop
    logic [spi_sub_pkg::fifo_level_w-1:0] level;
    logic [spi_sub_pkg::fifo_level_w-1:0] remaining;      // Old entries left after pop
    logic                                 at_data;
    logic                                 at_level;
    logic                                 push;
    logic                                 pop;

    assign at_data  = (address == spi_sub_pkg::addr_fifo_data);
    assign at_level = (address == spi_sub_pkg::addr_fifo_level);

    // Full and empty checked on the level before this cycle's strobes
    assign push = wr_en && at_data
               && (level != spi_sub_pkg::fifo_level_w'(spi_sub_pkg::fifo_depth));
    assign pop  = rd_en && at_data && (level != '0);

    assign next_rd_ptr = rd_ptr + spi_sub_pkg::fifo_ptr_w'(pop);
    assign remaining   = level - spi_sub_pkg::fifo_level_w'(pop);

    always_ff @(posedge spi_clock_in) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            wr_ptr <= wr_ptr + spi_sub_pkg::fifo_ptr_w'(push);   // Pointers wrap
            rd_ptr <= next_rd_ptr;
            level  <= level + spi_sub_pkg::fifo_level_w'(push)
                            - spi_sub_pkg::fifo_level_w'(pop);
        end
    end

    // Response shows the head as it will be after pending pop and push
    // Outside the strobe cycle both are low and this is the plain head
    always_comb begin
        response = '0;
        if (at_level) begin
            response = spi_sub_pkg::byte_w'(level);   // No strobes act here
        end else if (at_data) begin
            if (remaining != '0) begin
                response = mem[next_rd_ptr];
            end else if (push) begin
                response = wr_data;                 // Fresh byte becomes the head
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/register_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module register_bank (
    input  logic                               spi_clock_in,
    input  logic                               spi_resetn,
    input  logic [spi_sub_pkg::byte_w-1:0]     address,
    input  logic [spi_sub_pkg::count_w-1:0]    byte_count,
    input  logic                               wr_en,
    input  logic [spi_sub_pkg::byte_w-1:0]     wr_data,
    output logic [spi_sub_pkg::byte_w-1:0]     response
);

    logic [spi_sub_pkg::byte_w-1:0]        scratch [spi_sub_pkg::scratch_count];
    logic [spi_sub_pkg::byte_w-1:0]        offset;       // Address relative to base
    logic                                  is_scratch;
    logic [spi_sub_pkg::scratch_idx_w-1:0] wr_index;
    logic [spi_sub_pkg::scratch_idx_w-1:0] rd_index;

    assign offset     = address - spi_sub_pkg::addr_scratch_base;
    assign is_scratch = (offset < spi_sub_pkg::byte_w'(spi_sub_pkg::scratch_count));

    // Auto increment by byte count, wraps modulo the register count
    assign wr_index = offset[spi_sub_pkg::scratch_idx_w-1:0]
                    + byte_count[spi_sub_pkg::scratch_idx_w-1:0];

    // During the strobe cycle the shifter is already loading the next read byte
    // wr_en marks that cycle, so look one register ahead
    assign rd_index = wr_index + spi_sub_pkg::scratch_idx_w'(wr_en);

    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            for (int i = 0; i < spi_sub_pkg::scratch_count; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_en && is_scratch) begin
            scratch[wr_index] <= wr_data;   // Chip ID writes fall through here
        end
    end

    // Read mux, zero when not addressed
    always_comb begin
        response = '0;
        if (address == spi_sub_pkg::addr_chip_id) begin
            response = spi_sub_pkg::chip_id_value;     // Same at every count
        end else if (is_scratch) begin
            response = scratch[rd_index];
        end
    end

endmodule

`default_nettype wire

/* rtl/spi_sub_top.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_sub_top (
    input  logic spi_clock_in,
    input  logic spi_resetn,
    input  logic spi_select,       // Active low
    input  logic spi_data_in,
    output logic spi_data_out
);

    logic [spi_sub_pkg::byte_w-1:0]  address;
    logic [spi_sub_pkg::byte_w-1:0]  wr_data;
    logic                            wr_en;
    logic                            rd_en;
    logic [spi_sub_pkg::count_w-1:0] byte_count;
    logic [spi_sub_pkg::byte_w-1:0]  bank_response;
    logic [spi_sub_pkg::byte_w-1:0]  fifo_response;
    logic [spi_sub_pkg::byte_w-1:0]  response;

    // Idle targets drive zero so a plain OR is enough
    assign response = bank_response | fifo_response;

    spi_peripheral spi_peripheral_i (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .spi_select   (spi_select),
        .spi_data_in  (spi_data_in),
        .response     (response),
        .spi_data_out (spi_data_out),
        .address      (address),
        .wr_data      (wr_data),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .byte_count   (byte_count)
    );

    register_bank register_bank_i (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .address      (address),
        .byte_count   (byte_count),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .response     (bank_response)
    );

    byte_fifo byte_fifo_i (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .address      (address),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .response     (fifo_response)
    );

endmodule

`default_nettype wire

/* spi_peripheral/spi_bit_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_bit_counter (
    input  logic                                 spi_clock_in,
    input  logic                                 local_resetn,
    input  spi_sub_pkg::spi_phase_t              phase,
    output logic [spi_sub_pkg::bit_idx_w-1:0]    bit_index,
    output logic                                 byte_done,
    output logic [spi_sub_pkg::count_w-1:0]      byte_count
);

    // Set for one cycle after the last bit of a data byte
    logic count_pending;

    // Last bit of the byte is on the wire this cycle
    assign byte_done = (bit_index == '0);

    always_ff @(posedge spi_clock_in or negedge local_resetn) begin
        if (!local_resetn) begin
            bit_index     <= '1;              // MSB first
            count_pending <= 1'b0;
            byte_count    <= '0;
        end else begin
            bit_index <= bit_index - 1'b1;    // 0 rolls back to 7

            // Address byte does not count
            count_pending <= byte_done && (phase == spi_sub_pkg::phase_data);

            // Bump one edge late so the strobe cycle still sees the old count
            if (count_pending) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* spi_peripheral/spi_peripheral.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_peripheral (
    input  logic                               spi_clock_in,
    input  logic                               spi_resetn,
    input  logic                               spi_select,     // Active low
    input  logic                               spi_data_in,
    input  logic [spi_sub_pkg::byte_w-1:0]     response,
    output logic                               spi_data_out,
    output logic [spi_sub_pkg::byte_w-1:0]     address,
    output logic [spi_sub_pkg::byte_w-1:0]     wr_data,
    output logic                               wr_en,
    output logic                               rd_en,
    output logic [spi_sub_pkg::count_w-1:0]    byte_count
);

    logic                           local_resetn;
    logic                           byte_done;
    logic                           load_response;
    logic [spi_sub_pkg::byte_w-1:0] rx_byte;
    spi_sub_pkg::spi_phase_t        phase;

    // Deselect restarts the transaction state
    // Register and FIFO contents see only spi_resetn
    assign local_resetn = spi_resetn & ~spi_select;

    // Bit position stays internal to the counter
    spi_bit_counter bit_counter_i (
        .spi_clock_in (spi_clock_in),
        .local_resetn (local_resetn),
        .phase        (phase),
        .bit_index    (),
        .byte_done    (byte_done),
        .byte_count   (byte_count)
    );

    spi_phase_control phase_control_i (
        .spi_clock_in  (spi_clock_in),
        .local_resetn  (local_resetn),
        .byte_done     (byte_done),
        .rx_byte       (rx_byte),
        .phase         (phase),
        .address       (address),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .load_response (load_response)
    );

    spi_shifter shifter_i (
        .spi_clock_in  (spi_clock_in),
        .local_resetn  (local_resetn),
        .spi_data_in   (spi_data_in),
        .load_response (load_response),
        .response      (response),
        .rx_byte       (rx_byte),
        .wr_data       (wr_data),
        .spi_data_out  (spi_data_out)
    );

endmodule

`default_nettype wire

/* spi_peripheral/spi_phase_control.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_phase_control (
    input  logic                              spi_clock_in,
    input  logic                              local_resetn,
    input  logic                              byte_done,
    input  logic [spi_sub_pkg::byte_w-1:0]    rx_byte,
    output spi_sub_pkg::spi_phase_t           phase,
    output logic [spi_sub_pkg::byte_w-1:0]    address,
    output logic                              wr_en,
    output logic                              rd_en,
    output logic                              load_response
);

    spi_sub_pkg::spi_phase_t phase_next;
    logic                    address_done;   // Closing edge of the address byte
    logic                    data_done;      // Closing edge of a data byte

    assign address_done = byte_done && (phase == spi_sub_pkg::phase_address);
    assign data_done    = byte_done && (phase == spi_sub_pkg::phase_data);

    // Next state
    always_comb begin
        phase_next = phase;
        case (phase)
            spi_sub_pkg::phase_address: begin
                if (byte_done) begin
                    phase_next = spi_sub_pkg::phase_data;
                end
            end
            spi_sub_pkg::phase_data: begin
                phase_next = spi_sub_pkg::phase_data;   // Held until deselect
            end
            default: begin
                phase_next = spi_sub_pkg::phase_address;
            end
        endcase
    end

    always_ff @(posedge spi_clock_in or negedge local_resetn) begin
        if (!local_resetn) begin
            phase         <= spi_sub_pkg::phase_address;
            address       <= '0;                          // 0x00 is unmapped
            wr_en         <= 1'b0;
            rd_en         <= 1'b0;
            load_response <= 1'b0;
        end else begin
            phase <= phase_next;

            // rx_byte already includes the bit sampled on this edge
            if (address_done) begin
                address <= rx_byte;
            end

            // One cycle strobes, targets act on the following edge
            wr_en <= data_done;
            rd_en <= data_done;

            // Falling edge after any byte boundary starts a new read byte
            load_response <= byte_done;
        end
    end

endmodule

`default_nettype wire

/* spi_peripheral/spi_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_shifter (
    input  logic                              spi_clock_in,
    input  logic                              local_resetn,
    input  logic                              spi_data_in,
    input  logic                              load_response,
    input  logic [spi_sub_pkg::byte_w-1:0]    response,
    output logic [spi_sub_pkg::byte_w-1:0]    rx_byte,
    output logic [spi_sub_pkg::byte_w-1:0]    wr_data,
    output logic                              spi_data_out
);

    logic [spi_sub_pkg::byte_w-1:0] shift_reg;   // Bits taken so far
    logic [spi_sub_pkg::byte_w-1:0] tx_reg;      // Bits still to send, MSB next

    // Byte as it will stand after this edge
    // Lets the phase control latch the address on the closing edge itself
    assign rx_byte = {shift_reg[spi_sub_pkg::byte_w-2:0], spi_data_in};

    // Holds the complete byte during the strobe cycle after its last bit
    assign wr_data = shift_reg;

    // Receive side, mode 0 samples on the rising edge
    always_ff @(posedge spi_clock_in) begin
        shift_reg <= rx_byte;
    end

    // Transmit side changes on the falling edge
    always_ff @(negedge spi_clock_in or negedge local_resetn) begin
        if (!local_resetn) begin
            tx_reg       <= '0;
            spi_data_out <= 1'b0;             // Quiet during address byte
        end else if (load_response) begin
            spi_data_out <= response[spi_sub_pkg::byte_w-1];
            tx_reg       <= {response[spi_sub_pkg::byte_w-2:0], 1'b0};
        end else begin
            spi_data_out <= tx_reg[spi_sub_pkg::byte_w-1];
            tx_reg       <= {tx_reg[spi_sub_pkg::byte_w-2:0], 1'b0};   // Zero fill
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_spi_sub.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_sub;

    localparam int          clk_period     = 4;     // ns
    localparam int          directed_count = 6;
    localparam int          random_count   = 200;
    localparam int          timeout_ns     = (directed_count + random_count) * 64 * clk_period
                                           + 400;   // Margin for reset and idle gaps
    localparam logic [31:0] random_seed    = 32'hf4e97968;

    logic spi_clock_in;
    logic spi_resetn;
    logic spi_select;
    logic spi_data_in;
    logic spi_data_out;

    // Reference model
    logic [7:0] scratch_model [4];
    logic [7:0] fifo_model [$];

    int error_count;
    int check_count;

    spi_sub_top dut_i (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .spi_select   (spi_select),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    always #(clk_period / 2) spi_clock_in = ~spi_clock_in;

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected 0x%02h actual 0x%02h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    function automatic bit in_scratch(input logic [7:0] addr);
        return (int'(addr) >= int'(spi_sub_pkg::addr_scratch_base))
            && (int'(addr) < int'(spi_sub_pkg::addr_scratch_base)
                             + spi_sub_pkg::scratch_count);
    endfunction

    // Register hit by data byte k, wraps over the four registers
    function automatic int scratch_slot(input logic [7:0] addr, input int k);
        return (int'(addr) - int'(spi_sub_pkg::addr_scratch_base) + k)
             % spi_sub_pkg::scratch_count;
    endfunction

    function automatic logic [7:0] predict_read(input logic [7:0] addr, input int k);
        logic [7:0] result;
        result = 8'h00;                                   // Unmapped reads zero
        if (addr == spi_sub_pkg::addr_chip_id) begin
            result = spi_sub_pkg::chip_id_value;
        end else if (in_scratch(addr)) begin
            result = scratch_model[scratch_slot(addr, k)];
        end else if (addr == spi_sub_pkg::addr_fifo_data) begin
            if (fifo_model.size() > 0) begin
                result = fifo_model[0];                   // Head, empty gives zero
            end
        end else if (addr == spi_sub_pkg::addr_fifo_level) begin
            result = 8'(fifo_model.size());
        end
        return result;
    endfunction

    task automatic apply_write(input logic [7:0] addr, input int k, input logic [7:0] data);
        bit was_full;
        bit was_empty;
        // Full and empty judged before either strobe acts
        was_full  = (fifo_model.size() == spi_sub_pkg::fifo_depth);
        was_empty = (fifo_model.size() == 0);
        if (in_scratch(addr)) begin
            scratch_model[scratch_slot(addr, k)] = data;
        end else if (addr == spi_sub_pkg::addr_fifo_data) begin
            if (!was_empty) begin
                void'(fifo_model.pop_front());            // Every data byte reads too
            end
            if (!was_full) begin
                fifo_model.push_back(data);
            end
        end
    endtask

    // Called 0.5 ns after a rising edge, returns at the same point
    task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = 8'h00;
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_data_in = tx[i];                          // MSB first
            @(posedge spi_clock_in);
            rx[i] = spi_data_out;                         // Settled since the falling edge
            #0.5;
        end
    endtask

    // cut_bits above zero drops select partway through one more byte
    task automatic run_transfer(input logic [7:0] addr, input int n_bytes, input int cut_bits);
        logic [7:0] rx;
        logic [7:0] tx;
        logic [7:0] expected;
        spi_select = 1'b0;
        shift_bits(addr, 8, rx);
        check_value("spi_data_out in address phase", 8'h00, rx);
        for (int k = 0; k < n_bytes; k++) begin
            tx       = 8'($urandom_range(0, 255));
            expected = predict_read(addr, k);             // Before write k lands
            shift_bits(tx, 8, rx);
            check_value($sformatf("spi_data_out addr 0x%02h byte %0d", addr, k), expected, rx);
            apply_write(addr, k, tx);
        end
        if (cut_bits > 0) begin
            tx = 8'($urandom_range(0, 255));
            shift_bits(tx, cut_bits, rx);                 // Byte never completes
        end else begin
            spi_data_in = 1'b0;
            @(posedge spi_clock_in);                      // Last write strobe acts here
            #0.5;
        end
        spi_select  = 1'b1;
        spi_data_in = 1'b0;
        repeat (2) @(posedge spi_clock_in);
        #0.5;
        check_value("spi_data_out while deselected", 8'h00, {7'h00, spi_data_out});
    endtask

    function automatic logic [7:0] pick_address();
        logic [7:0] addr;
        case ($urandom_range(0, 9))
            0: addr = spi_sub_pkg::addr_chip_id;
            1, 2, 3: addr = spi_sub_pkg::addr_scratch_base + 8'($urandom_range(0, 3));
            4, 5: addr = spi_sub_pkg::addr_fifo_data;
            6: addr = spi_sub_pkg::addr_fifo_level;
            7: addr = 8'h40 | 8'($urandom_range(0, 15));
            8: begin
                // Neighbours of the mapped ranges
                case ($urandom_range(0, 3))
                    0: addr = 8'h00;
                    1: addr = 8'h0F;
                    2: addr = 8'h14;
                    default: addr = 8'h22;
                endcase
            end
            default: addr = 8'h80 | 8'($urandom_range(0, 127));
        endcase
        return addr;
    endfunction

    initial begin
        logic [7:0] addr;
        spi_clock_in = 1'b0;
        spi_resetn   = 1'b0;
        spi_select   = 1'b1;
        spi_data_in  = 1'b0;
        error_count  = 0;
        check_count  = 0;
        for (int i = 0; i < spi_sub_pkg::scratch_count; i++) begin
            scratch_model[i] = 8'h00;                     // Matches reset state
        end
        void'($urandom(random_seed));
        repeat (2) @(posedge spi_clock_in);
        #0.5;
        spi_resetn = 1'b1;
        @(posedge spi_clock_in);
        #0.5;

        // Directed opening
        run_transfer(spi_sub_pkg::addr_chip_id, 4, 0);
        run_transfer(spi_sub_pkg::addr_fifo_level, 1, 0);
        run_transfer(spi_sub_pkg::addr_fifo_data, 3, 0);  // First pop on empty
        run_transfer(spi_sub_pkg::addr_fifo_level, 2, 0);
        run_transfer(8'h12, 6, 0);                        // Wraps past 0x13
        run_transfer(spi_sub_pkg::addr_scratch_base, 4, 0);

        for (int t = 0; t < random_count; t++) begin
            addr = pick_address();
            if ($urandom_range(0, 7) == 0) begin
                run_transfer(addr, $urandom_range(0, 3), $urandom_range(1, 7));
            end else begin
                run_transfer(addr, $urandom_range(1, 6), 0);
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before all transfers finished", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
